// File: hw/fpga_v1_pkg.sv
// shared types and sizes for the host register core; the 3-bit opcode values are fixed by the host link
`default_nettype none

package fpga_v1_pkg;

    // ----------------------------------------------------------------------
    // sizes
    // ----------------------------------------------------------------------
    localparam int HUB_DEPTH    = 64;                   // hub quadlets
    localparam int HUB_AW       = 6;                    // hub index width
    localparam int NUM_CHANNELS = 4;                    // motor channels on the board
    localparam logic [31:0] FW_VERSION = 32'h0001_0008; // returned by REG_VERSION
    localparam int WDOG_TICK    = 16;                   // sysclk cycles per period unit

    // ----------------------------------------------------------------------
    // address map
    // ----------------------------------------------------------------------

    // address space, addr[15:12]
    typedef enum logic [3:0] {
        ADDR_MAIN = 4'h0,   // board registers, channel 0
        ADDR_HUB  = 4'h2    // broadcast hub memory
    } addr_space_e;

    // board register offsets, addr[3:0] of main space
    typedef enum logic [3:0] {
        REG_STATUS  = 4'd0,     // board id, timeout flag, channel count
        REG_SCRATCH = 4'd1,     // free read/write word
        REG_VERSION = 4'd2,     // firmware version, read only
        REG_WDOG    = 4'd3      // watchdog period in WDOG_TICK units, 0 = off
    } main_reg_e;

    // ----------------------------------------------------------------------
    // host command and register bus
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        CMD_QREAD     = 3'd0,   // quadlet read
        CMD_QWRITE    = 3'd1,   // quadlet write
        CMD_RT_WSTART = 3'd2,   // real-time block write start
        CMD_RT_WWORD  = 3'd3,   // one word of a real-time block write
        CMD_RT_READ   = 3'd4    // real-time block read, index in addr
    } cmd_op_e;

    // one parsed command per strobe
    typedef struct packed {
        cmd_op_e     op;
        logic [15:0] addr;
        logic [31:0] data;
    } host_cmd_t;

    // write bus, one wen per target
    typedef struct packed {
        logic        main_wen;  // board register write
        logic        hub_wen;   // hub memory write
        logic [15:0] waddr;
        logic [31:0] wdata;
    } reg_wr_t;

endpackage

`default_nettype wire

// File: hw/host_cmd_decoder.sv
// host command decoder; commands need 3 idle cycles after a read, anything arriving mid-read is dropped
`timescale 1ns/1ps
`default_nettype none

module host_cmd_decoder (
    input  wire logic                  sysclk,
    input  wire logic                  rst_n,
    input  wire logic                  cmd_valid,   // one-cycle command strobe
    input  wire fpga_v1_pkg::host_cmd_t cmd,
    input  wire logic [3:0]            board_id,    // rotary switch
    output fpga_v1_pkg::reg_wr_t       wr,          // write bus to both targets
    output logic [15:0]                raddr,       // registered read address
    input  wire logic [31:0]           hub_rdata,   // one cycle after raddr
    input  wire logic [31:0]           main_rdata,  // same cycle as raddr
    output logic                       rsp_valid,   // one-cycle response strobe
    output logic [31:0]                rsp_data
);
    import fpga_v1_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,    // no read pending
        RD_ADDR,    // raddr valid, board regs answer now
        RD_MEM      // waiting on hub memory register
    } rd_state_e;

    rd_state_e         rd_state;
    logic              accept;          // command taken this cycle
    logic [3:0]        cmd_space;
    logic              board_match;     // rt word addressed to this board
    logic [HUB_AW-1:0] rt_index;        // next hub slot for rt words
    logic [HUB_AW:0]   rt_rd_idx;       // rt read index, 0 = status
    logic [HUB_AW:0]   rt_rd_prev;
    logic              main_wen_d;
    logic              hub_wen_d;
    logic [15:0]       waddr_d;
    logic              rt_clear;
    logic              rt_step;
    logic              rd_start;
    logic [15:0]       raddr_d;
    logic              main_wen_q;
    logic              hub_wen_q;
    logic [15:0]       waddr_q;
    logic [31:0]       wdata_q;
    logic [3:0]        rd_space;

    assign accept      = cmd_valid && (rd_state == RD_IDLE);   // no back-pressure
    assign cmd_space   = cmd.addr[15:12];
    assign board_match = (cmd.data[11:8] == board_id);
    assign rt_rd_idx   = cmd.addr[HUB_AW:0];
    assign rt_rd_prev  = rt_rd_idx - 1'b1;
    assign rd_space    = raddr[15:12];

    // ----------------------------------------------------------------------
    // command decode
    // ----------------------------------------------------------------------
    always_comb begin
        main_wen_d = 1'b0;
        hub_wen_d  = 1'b0;
        waddr_d    = cmd.addr;
        rt_clear   = 1'b0;
        rt_step    = 1'b0;
        rd_start   = 1'b0;
        raddr_d    = cmd.addr;
        if (accept) begin
            case (cmd.op)
                CMD_QREAD: rd_start = 1'b1;     // unmapped space answers 0 later
                CMD_QWRITE: begin
                    main_wen_d = (cmd_space == ADDR_MAIN);
                    hub_wen_d  = (cmd_space == ADDR_HUB);     // other spaces ignored
                end
                CMD_RT_WSTART: rt_clear = 1'b1;
                CMD_RT_WWORD: begin
                    // only words carrying our board id land in the hub
                    hub_wen_d = board_match;
                    rt_step   = board_match;
                    waddr_d   = {ADDR_HUB, {(12 - HUB_AW){1'b0}}, rt_index};
                end
                CMD_RT_READ: begin
                    rd_start = 1'b1;
                    if (rt_rd_idx == '0)
                        raddr_d = {ADDR_MAIN, 8'h00, REG_STATUS};    // index 0 is status
                    else
                        raddr_d = {ADDR_HUB, {(12 - HUB_AW){1'b0}}, rt_rd_prev[HUB_AW-1:0]};
                end
                default: ;  // unknown opcode, dropped
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // write bus, one cycle after the strobe
    // ----------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            main_wen_q <= 1'b0;
            hub_wen_q  <= 1'b0;
            rt_index   <= '0;
        end else begin
            main_wen_q <= main_wen_d;
            hub_wen_q  <= hub_wen_d;
            if (rt_clear)
                rt_index <= '0;
            else if (rt_step)
                rt_index <= rt_index + 1'b1;    // wraps past the last slot
        end
    end

    always_ff @(posedge sysclk) begin
        waddr_q <= waddr_d;     // qualified by the wen bits
        wdata_q <= cmd.data;
    end

    assign wr = '{main_wen: main_wen_q, hub_wen: hub_wen_q, waddr: waddr_q, wdata: wdata_q};

    // ----------------------------------------------------------------------
    // read sequencing and response mux
    // ----------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state  <= RD_IDLE;
            rsp_valid <= 1'b0;
            raddr     <= '0;
        end else begin
            rsp_valid <= 1'b0;
            case (rd_state)
                RD_IDLE: begin
                    if (rd_start) begin
                        raddr    <= raddr_d;
                        rd_state <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (rd_space == ADDR_HUB) begin
                        rd_state <= RD_MEM;     // memory read register in the way
                    end else begin
                        rsp_valid <= 1'b1;
                        rd_state  <= RD_IDLE;
                    end
                end
                RD_MEM: begin
                    rsp_valid <= 1'b1;
                    rd_state  <= RD_IDLE;
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // data follows rsp_valid, cycle for cycle
    always_ff @(posedge sysclk) begin
        if (rd_state == RD_MEM)
            rsp_data <= hub_rdata;
        else if (rd_state == RD_ADDR)
            rsp_data <= (rd_space == ADDR_MAIN) ? main_rdata : 32'd0;
    end

endmodule

`default_nettype wire

// File: hw/hub_buffer.sv
// hub quadlet memory, one write and one registered read port; contents are undefined until written
`timescale 1ns/1ps
`default_nettype none

module hub_buffer (
    input  wire logic                 sysclk,
    input  wire logic                 rst_n,
    input  wire fpga_v1_pkg::reg_wr_t wr,         // only hub_wen is looked at
    input  wire logic [15:0]          raddr,      // low bits index the memory
    output logic [31:0]               hub_rdata   // one cycle after raddr
);
    import fpga_v1_pkg::*;

    // ----------------------------------------------------------------------
    // storage
    // ----------------------------------------------------------------------
    logic [31:0]       mem [HUB_DEPTH];
    logic [HUB_AW-1:0] widx;
    logic [HUB_AW-1:0] ridx;

    // space was checked by the decoder, only the index matters here
    assign widx = wr.waddr[HUB_AW-1:0];
    assign ridx = raddr[HUB_AW-1:0];

    // write port
    always_ff @(posedge sysclk) begin
        if (wr.hub_wen)
            mem[widx] <= wr.wdata;
    end

    // ----------------------------------------------------------------------
    // read port
    // ----------------------------------------------------------------------

    // free running read every cycle, output register cleared on reset
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            hub_rdata <= 32'd0;
        else
            hub_rdata <= mem[ridx];     // read before a same-cycle write
    end

endmodule

`default_nettype wire

// File: hw/board_regs.sv
// board registers and watchdog; the timeout flag holds until wdog_clear even if the period changes
`timescale 1ns/1ps
`default_nettype none

module board_regs (
    input  wire logic                 sysclk,
    input  wire logic                 rst_n,
    input  wire fpga_v1_pkg::reg_wr_t wr,                 // write bus from the decoder
    input  wire logic [15:0]          raddr,              // offset in bits 3:0
    input  wire logic [3:0]           board_id,
    input  wire logic                 wdog_clear,         // pulse, drops the timeout flag
    output logic [31:0]               main_rdata,         // combinational on raddr
    output logic                      wdog_timeout,       // level
    output logic [2:0]                wdog_period_status  // log2 bucket of the period
);
    import fpga_v1_pkg::*;

    logic [31:0] scratch;
    logic [15:0] wdog_period;       // in WDOG_TICK units, 0 = disabled
    logic [19:0] wdog_count;        // sysclk cycles since last refresh
    logic [19:0] wdog_limit;
    logic        wdog_refresh;
    logic [31:0] status;

    // ----------------------------------------------------------------------
    // register writes
    // ----------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            wdog_period <= 16'd0;
        else if (wr.main_wen && (wr.waddr[3:0] == REG_WDOG))
            wdog_period <= wr.wdata[15:0];
    end

    always_ff @(posedge sysclk) begin
        if (wr.main_wen && (wr.waddr[3:0] == REG_SCRATCH))
            scratch <= wr.wdata;
    end

    // ----------------------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------------------
    assign wdog_limit   = 20'(wdog_period) * 20'(WDOG_TICK);
    assign wdog_refresh = wr.main_wen || wr.hub_wen;   // any decoded write feeds it

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            wdog_count   <= 20'd0;
            wdog_timeout <= 1'b0;
        end else begin
            if (wdog_clear)
                wdog_timeout <= 1'b0;
            if (wdog_refresh || wdog_clear || (wdog_period == 16'd0))
                wdog_count <= 20'd0;    // reload, or parked while disabled
            else if (wdog_count == wdog_limit)
                wdog_timeout <= 1'b1;   // count holds at the limit
            else
                wdog_count <= wdog_count + 1'b1;
        end
    end

    // bucket = msb position + 1, so period 1 -> 1, 2..3 -> 2, 4..7 -> 3 ...
    always_comb begin
        wdog_period_status = 3'd0;
        for (int i = 0; i < 16; i++) begin
            if (wdog_period[i])
                wdog_period_status = (i >= 6) ? 3'd7 : 3'(i + 1);    // capped at 7
        end
    end

    // ----------------------------------------------------------------------
    // read mux
    // ----------------------------------------------------------------------

    // channel count in 23:20, timeout in 8, board id in 3:0
    assign status = {8'd0, 4'(NUM_CHANNELS), 11'd0, wdog_timeout, 4'd0, board_id};

    always_comb begin
        case (raddr[3:0])
            REG_STATUS:  main_rdata = status;
            REG_SCRATCH: main_rdata = scratch;
            REG_VERSION: main_rdata = FW_VERSION;
            REG_WDOG:    main_rdata = {16'd0, wdog_period};
            default:     main_rdata = 32'd0;    // unused offsets read 0
        endcase
    end

endmodule

`default_nettype wire

// File: hw/fpga_v1_core.sv
// register-access core top level; parsed host commands in, one response strobe per read out
`timescale 1ns/1ps
`default_nettype none

module fpga_v1_core (
    input  wire logic                   sysclk,
    input  wire logic                   rst_n,
    // host side
    input  wire logic                   cmd_valid,          // one-cycle strobe
    input  wire fpga_v1_pkg::host_cmd_t cmd,
    output wire logic                   rsp_valid,          // one-cycle strobe
    output wire logic [31:0]            rsp_data,
    // board
    input  wire logic [3:0]             board_id,
    input  wire logic                   wdog_clear,
    output wire logic                   wdog_timeout,
    output wire logic [2:0]             wdog_period_status
);
    import fpga_v1_pkg::*;

    // ----------------------------------------------------------------------
    // register bus
    // ----------------------------------------------------------------------
    wire reg_wr_t     wr;           // shared by both targets
    wire logic [15:0] raddr;
    wire logic [31:0] hub_rdata;    // registered
    wire logic [31:0] main_rdata;   // combinational

    // producer, turns commands into bus cycles and routes reads back
    host_cmd_decoder i_decoder (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .board_id   (board_id),
        .wr         (wr),
        .raddr      (raddr),
        .hub_rdata  (hub_rdata),
        .main_rdata (main_rdata),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

    // broadcast quadlets
    hub_buffer i_hub (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .wr        (wr),
        .raddr     (raddr),
        .hub_rdata (hub_rdata)
    );

    // channel 0 board registers and watchdog
    board_regs i_regs (
        .sysclk             (sysclk),
        .rst_n              (rst_n),
        .wr                 (wr),
        .raddr              (raddr),
        .board_id           (board_id),
        .wdog_clear         (wdog_clear),
        .main_rdata         (main_rdata),
        .wdog_timeout       (wdog_timeout),
        .wdog_period_status (wdog_period_status)
    );

endmodule

`default_nettype wire

// File: tb/fpga_v1_core_properties.sv
// timing checks for the register core; assumes the host keeps 3 idle cycles after every command
`timescale 1ns/1ps
`default_nettype none

module fpga_v1_core_properties (
    input wire logic                   sysclk,
    input wire logic                   rst_n,
    input wire logic                   cmd_valid,
    input wire fpga_v1_pkg::host_cmd_t cmd,
    input wire fpga_v1_pkg::reg_wr_t   wr,
    input wire logic                   rsp_valid,
    input wire logic                   wdog_timeout
);
    import fpga_v1_pkg::*;

    logic hub_read;     // answered from the memory register
    logic reg_read;     // board regs or unmapped

    assign hub_read = cmd_valid && (((cmd.op == CMD_QREAD) && (cmd.addr[15:12] == ADDR_HUB))
                      || ((cmd.op == CMD_RT_READ) && (cmd.addr[HUB_AW:0] != '0)));
    assign reg_read = cmd_valid && ((cmd.op == CMD_QREAD) || (cmd.op == CMD_RT_READ)) && !hub_read;

    // ----------------------------------------------------------------------
    a_spacing: assert property (@(posedge sysclk) disable iff (!rst_n)
        cmd_valid |=> !cmd_valid ##1 !cmd_valid ##1 !cmd_valid)
        else $error("command strobe inside a read, it gets dropped");
    a_reg_rsp: assert property (@(posedge sysclk) disable iff (!rst_n)
        reg_read |-> ##2 rsp_valid) else $error("register read response late");
    a_hub_rsp: assert property (@(posedge sysclk) disable iff (!rst_n)
        hub_read |-> ##3 rsp_valid) else $error("hub read response late");
    a_one_wen: assert property (@(posedge sysclk) disable iff (!rst_n)
        !(wr.main_wen && wr.hub_wen)) else $error("both write enables high");
    a_reset: assert property (@(posedge sysclk)
        !rst_n |-> !rsp_valid && !wr.main_wen && !wr.hub_wen && !wdog_timeout)
        else $error("output active in reset");

endmodule

`default_nettype wire

// File: tb/tb_fpga_v1_core.sv
// testbench for the register core; run from the project root, board id fixed at 5
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_v1_core;
    import fpga_v1_pkg::*;

    localparam int RSP_LIMIT  = 10;                 // cycles allowed for a response
    localparam int WDOG_LIMIT = 2 * WDOG_TICK + 4;  // timeout rise, period 2

    logic        sysclk;
    logic        rst_n;
    logic        cmd_valid;
    host_cmd_t   cmd;
    logic        rsp_valid;
    logic [31:0] rsp_data;
    logic [3:0]  board_id;
    logic        wdog_clear;
    logic        wdog_timeout;
    logic [2:0]  wdog_period_status;
    int          seed = 42318;

    fpga_v1_core i_dut (.*);

    bind fpga_v1_core fpga_v1_core_properties i_props (
        .sysclk(sysclk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd(cmd),
        .wr(wr), .rsp_valid(rsp_valid), .wdog_timeout(wdog_timeout)
    );

    always #2 sysclk = ~sysclk;    // 4 ns

    // ----------------------------------------------------------------------
    // helpers, all called and returning just after a rising edge
    // ----------------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
            fail_run($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic tick(input int n);
        repeat (n) begin
            @(posedge sysclk);
            #1;     // drive and sample away from the edge
        end
    endtask

    // one-cycle command strobe
    task automatic send_cmd(input cmd_op_e op, input logic [15:0] addr, input logic [31:0] data);
        cmd = '{op: op, addr: addr, data: data};
        cmd_valid = 1'b1;
        tick(1);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_rsp(output logic [31:0] data);
        for (int n = 0; !rsp_valid; n++) begin
            if (n == RSP_LIMIT)
                fail_run("no response strobe after a read command");
            else
                tick(1);
        end
        data = rsp_data;
    endtask

    // bucket is floor(log2(p)) + 1, capped at 7, 0 when disabled
    function automatic logic [2:0] period_bucket(input logic [15:0] p);
        int b;
        b = 0;
        for (int i = 0; i < 16; i++)
            if (32'(p) >= (32'd1 << i)) b = i + 1;
        return (b > 7) ? 3'd7 : 3'(b);
    endfunction

    task automatic check_bucket(input logic [15:0] p);
        send_cmd(CMD_QWRITE, {ADDR_MAIN, 8'h00, REG_WDOG}, {16'd0, p});
        tick(4);
        check($sformatf("period bucket %h", p), 32'(period_bucket(p)), 32'(wdog_period_status));
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        int          fd;
        int          line_no;
        string       line;
        logic [2:0]  op_v;
        logic [15:0] addr_v;
        logic [31:0] data_v;
        logic [3:0]  rsp_v;
        logic [31:0] expd_v;
        logic [31:0] got;
        logic [31:0] last_scratch;

        sysclk     = 1'b0;
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        board_id   = 4'h5;
        wdog_clear = 1'b0;
        tick(5);                    // reset held 5 cycles
        rst_n = 1'b1;
        tick(1);

        fd = $fopen("tb/stimulus_input.txt", "r");
        if (fd == 0)
            fail_run("cannot open tb/stimulus_input.txt");
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            line_no++;
            if (line.len() < 2 || line[0] == "#")
                continue;           // blank or column notes
            if ($sscanf(line, "%h %h %h %h %h", op_v, addr_v, data_v, rsp_v, expd_v) != 5)
                fail_run($sformatf("stimulus line %0d cannot be parsed", line_no));
            send_cmd(cmd_op_e'(op_v), addr_v, data_v);
            if (rsp_v != 4'd0) begin
                wait_rsp(got);
                check($sformatf("stimulus line %0d", line_no), expd_v, got);
            end
            tick(4);                // host gap
        end
        $fclose(fd);

        // watchdog, period 2 and no traffic
        send_cmd(CMD_QWRITE, {ADDR_MAIN, 8'h00, REG_WDOG}, 32'd2);
        for (int n = 0; !wdog_timeout; n++) begin
            if (n == WDOG_LIMIT)
                fail_run("watchdog timeout did not rise with period 2");
            else
                tick(1);
        end
        check("period bucket 2", 32'(period_bucket(16'd2)), 32'(wdog_period_status));
        wdog_clear = 1'b1;
        tick(1);
        wdog_clear = 1'b0;
        check("wdog clear", 32'd0, 32'(wdog_timeout));

        // scratch writes every 8 cycles keep the flag down
        last_scratch = '0;
        for (int i = 0; i < 10; i++) begin
            last_scratch = $random(seed);
            send_cmd(CMD_QWRITE, {ADDR_MAIN, 8'h00, REG_SCRATCH}, last_scratch);
            for (int c = 0; c < 7; c++) begin
                check("wdog refresh", 32'd0, 32'(wdog_timeout));
                tick(1);
            end
        end
        send_cmd(CMD_QREAD, {ADDR_MAIN, 8'h00, REG_SCRATCH}, 32'd0);
        wait_rsp(got);
        check("scratch random", last_scratch, got);
        tick(4);

        check_bucket(16'h0025);
        check_bucket(16'h0100);     // capped
        check_bucket(16'h0001);
        check_bucket(16'h0000);     // disabled

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: fpga_v1_core.f
hw/fpga_v1_pkg.sv
hw/host_cmd_decoder.sv
hw/hub_buffer.sv
hw/board_regs.sv
hw/fpga_v1_core.sv
tb/fpga_v1_core_properties.sv
tb/tb_fpga_v1_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fpga_v1_core
FILELIST  ?= fpga_v1_core.f
FLAGS     ?= --binary --timing --assert -Wno-fatal
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb/stimulus_input.txt
# columns: opcode addr data rsp_expected expected_data, all hex
# opcode: 0 qread, 1 qwrite, 2 rt_wstart, 3 rt_wword, 4 rt_read
1 0001 a5a55a5a 0 00000000
0 0001 00000000 1 a5a55a5a
0 0002 00000000 1 00010008
1 2000 11111111 0 00000000
1 2007 deadbeef 0 00000000
1 203f cafef00d 0 00000000
0 2000 00000000 1 11111111
0 2007 00000000 1 deadbeef
0 203f 00000000 1 cafef00d
0 5000 00000000 1 00000000
1 5001 12345678 0 00000000
0 0001 00000000 1 a5a55a5a
0 0000 00000000 1 00400005
2 0000 00000000 0 00000000
3 0000 00000501 0 00000000
3 0000 00000302 0 00000000
3 0000 00000503 0 00000000
3 0000 00000f04 0 00000000
3 0000 00000505 0 00000000
4 0001 00000000 1 00000501
4 0002 00000000 1 00000503
4 0003 00000000 1 00000505
4 0000 00000000 1 00400005
